//--- design/front_cfg_pkg.sv
package front_cfg_pkg;

  // bundles held by each per-thread queue
  localparam int QUEUE_DEPTH = 4;

  // credits the decoder grants at reset
  localparam int BUNDLE_CREDITS = 4;

  // bundle address, counted in bundles
  localparam int ADDR_WIDTH = 16;

  localparam int BUNDLE_WIDTH = 64;

  // thread start addresses
  localparam logic [ADDR_WIDTH-1:0] THREAD0_RESET_ADDR = 16'h0000;
  localparam logic [ADDR_WIDTH-1:0] THREAD1_RESET_ADDR = 16'h0100;

endpackage

//--- design/front_types_pkg.sv
package front_types_pkg;

  typedef logic [front_cfg_pkg::ADDR_WIDTH-1:0] addr_t;

  typedef logic [front_cfg_pkg::BUNDLE_WIDTH-1:0] bundle_t;

  typedef logic thread_t;

  // wide enough for 0 up to the full credit count
  typedef logic [$clog2(front_cfg_pkg::BUNDLE_CREDITS+1)-1:0] credit_t;

  // refill state per thread
  // drop marks a refill still owed by the bus after a redirect
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT,
    FETCH_DROP
  } fetch_state_e;

endpackage

//--- design/front_ifs.sv
// head of one thread queue
interface queue_if;
  logic                    avail;
  front_types_pkg::addr_t   addr;
  front_types_pkg::bundle_t data;
  logic                    pop;

  modport producer (output avail, output addr, output data, input pop);
  modport consumer (input avail, input addr, input data, output pop);
endinterface

// chosen bundle toward the issue register
interface issue_if;
  logic                     valid;
  front_types_pkg::thread_t thread;
  front_types_pkg::addr_t   addr;
  front_types_pkg::bundle_t data;
  logic                     accept;

  modport source (output valid, output thread, output addr, output data, input accept);
  modport sink (input valid, input thread, input addr, input data, output accept);
endinterface

//--- design/thread_fetch.sv
module thread_fetch #(
  parameter int thread_id = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     redirect,
  input  front_types_pkg::addr_t   redirect_addr,
  input  logic                     grant,
  input  logic                     bus_en,
  input  front_types_pkg::bundle_t bus_data,
  output logic                     fetch_req,
  output front_types_pkg::addr_t   fetch_addr,
  queue_if.producer                q
);

  front_types_pkg::fetch_state_e state;

  front_types_pkg::addr_t   addr_q [front_cfg_pkg::QUEUE_DEPTH];
  front_types_pkg::bundle_t data_q [front_cfg_pkg::QUEUE_DEPTH];

  logic [$clog2(front_cfg_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(front_cfg_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(front_cfg_pkg::QUEUE_DEPTH+1)-1:0] count;
  logic                                            push;

  // a refill landing together with a redirect is dropped
  assign push = (state == front_types_pkg::FETCH_WAIT) && bus_en && !redirect;

  // no refill requests while in reset
  assign fetch_req = !rst && (state == front_types_pkg::FETCH_IDLE) &&
                     (count < front_cfg_pkg::QUEUE_DEPTH) && !redirect;

  // hide the head while the queue is being flushed
  assign q.avail = (count != '0) && !redirect;
  assign q.addr  = addr_q[rd_ptr];
  assign q.data  = data_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= front_types_pkg::FETCH_IDLE;
      fetch_addr <= (thread_id == 0) ? front_cfg_pkg::THREAD0_RESET_ADDR :
                                       front_cfg_pkg::THREAD1_RESET_ADDR;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
    end else if (redirect) begin
      fetch_addr <= redirect_addr;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      // refill still owed unless it arrives right now
      state      <= (state != front_types_pkg::FETCH_IDLE && !bus_en) ?
                    front_types_pkg::FETCH_DROP : front_types_pkg::FETCH_IDLE;
    end else begin
      if (q.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push) begin
        wr_ptr     <= wr_ptr + 1'b1;
        fetch_addr <= fetch_addr + 1'b1;
      end
      if (push && !q.pop) begin
        count <= count + 1'b1;
      end else if (!push && q.pop) begin
        count <= count - 1'b1;
      end
      case (state)
        front_types_pkg::FETCH_IDLE: if (grant) state <= front_types_pkg::FETCH_WAIT;
        front_types_pkg::FETCH_WAIT: if (bus_en) state <= front_types_pkg::FETCH_IDLE;
        front_types_pkg::FETCH_DROP: if (bus_en) state <= front_types_pkg::FETCH_IDLE;
        default: state <= front_types_pkg::FETCH_IDLE;
      endcase
    end
  end

  // fetch_addr still holds the requested address while waiting
  always_ff @(posedge clk) begin
    if (push) begin
      addr_q[wr_ptr] <= fetch_addr;
      data_q[wr_ptr] <= bus_data;
    end
  end

endmodule

//--- design/bus_request_arb.sv
module bus_request_arb (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fetch_req0,
  input  logic                     fetch_req1,
  input  front_types_pkg::addr_t   fetch_addr0,
  input  front_types_pkg::addr_t   fetch_addr1,
  output logic                     grant0,
  output logic                     grant1,
  output logic                     req_en,
  output front_types_pkg::thread_t req_thread,
  output front_types_pkg::addr_t   req_addr
);

  front_types_pkg::thread_t last_grant;

  // on conflict the thread not granted last time wins
  assign grant0 = fetch_req0 && (!fetch_req1 || last_grant == 1'b1);
  assign grant1 = fetch_req1 && (!fetch_req0 || last_grant == 1'b0);

  assign req_en     = grant0 || grant1;
  assign req_thread = grant1;
  assign req_addr   = grant1 ? fetch_addr1 : fetch_addr0;

  // reset to thread 1 so thread 0 wins the first tie
  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= 1'b1;
    end else if (req_en) begin
      last_grant <= req_thread;
    end
  end

endmodule

//--- design/thread_select.sv
module thread_select (
  input  logic      clk,
  input  logic      rst,
  queue_if.consumer q0,
  queue_if.consumer q1,
  issue_if.source   iss
);

  front_types_pkg::thread_t last_thread;
  front_types_pkg::thread_t pick;
  logic                     fire;

  // single thread with work takes it, otherwise alternate
  always_comb begin
    if (q0.avail && !q1.avail) begin
      pick = 1'b0;
    end else if (q1.avail && !q0.avail) begin
      pick = 1'b1;
    end else begin
      pick = ~last_thread;
    end
  end

  assign iss.valid  = q0.avail || q1.avail;
  assign iss.thread = pick;
  assign iss.addr   = pick ? q1.addr : q0.addr;
  assign iss.data   = pick ? q1.data : q0.data;

  assign fire = iss.valid && iss.accept;

  assign q0.pop = fire && (pick == 1'b0);
  assign q1.pop = fire && (pick == 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      last_thread <= 1'b1;
    end else if (fire) begin
      last_thread <= pick;
    end
  end

endmodule

//--- design/bundle_issue.sv
module bundle_issue (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     credit_return,
  issue_if.sink                    iss,
  output logic                     bundle_valid,
  output front_types_pkg::thread_t bundle_thread,
  output front_types_pkg::addr_t   bundle_addr,
  output front_types_pkg::bundle_t bundle_data
);

  front_types_pkg::credit_t credits;
  logic                     fire;

  assign iss.accept = (credits != '0);
  assign fire       = iss.valid && iss.accept;

  // a send and a return in one cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      credits      <= front_types_pkg::credit_t'(front_cfg_pkg::BUNDLE_CREDITS);
      bundle_valid <= 1'b0;
    end else begin
      bundle_valid <= fire;
      if (fire && !credit_return) begin
        credits <= credits - 1'b1;
      end else if (!fire && credit_return) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      bundle_thread <= iss.thread;
      bundle_addr   <= iss.addr;
      bundle_data   <= iss.data;
    end
  end

endmodule

//--- design/fetch_front.sv
module fetch_front (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     redirect,
  input  front_types_pkg::thread_t redirect_thread,
  input  front_types_pkg::addr_t   redirect_addr,
  input  logic                     bus_en,
  input  front_types_pkg::thread_t bus_thread,
  input  front_types_pkg::bundle_t bus_data,
  input  logic                     credit_return,
  output logic                     req_en,
  output front_types_pkg::thread_t req_thread,
  output front_types_pkg::addr_t   req_addr,
  output logic                     bundle_valid,
  output front_types_pkg::thread_t bundle_thread,
  output front_types_pkg::addr_t   bundle_addr,
  output front_types_pkg::bundle_t bundle_data
);

  logic                   redirect0;
  logic                   redirect1;
  logic                   bus_en0;
  logic                   bus_en1;
  logic                   fetch_req0;
  logic                   fetch_req1;
  logic                   grant0;
  logic                   grant1;
  front_types_pkg::addr_t fetch_addr0;
  front_types_pkg::addr_t fetch_addr1;

  queue_if q0 ();
  queue_if q1 ();
  issue_if iss ();

  // steer redirect and refill to their thread
  assign redirect0 = redirect && !redirect_thread;
  assign redirect1 = redirect && redirect_thread;
  assign bus_en0   = bus_en && !bus_thread;
  assign bus_en1   = bus_en && bus_thread;

  thread_fetch #(.thread_id(0)) i_fetch0 (
    .clk           (clk),
    .rst           (rst),
    .redirect      (redirect0),
    .redirect_addr (redirect_addr),
    .grant         (grant0),
    .bus_en        (bus_en0),
    .bus_data      (bus_data),
    .fetch_req     (fetch_req0),
    .fetch_addr    (fetch_addr0),
    .q             (q0)
  );

  thread_fetch #(.thread_id(1)) i_fetch1 (
    .clk           (clk),
    .rst           (rst),
    .redirect      (redirect1),
    .redirect_addr (redirect_addr),
    .grant         (grant1),
    .bus_en        (bus_en1),
    .bus_data      (bus_data),
    .fetch_req     (fetch_req1),
    .fetch_addr    (fetch_addr1),
    .q             (q1)
  );

  bus_request_arb i_arb (
    .clk         (clk),
    .rst         (rst),
    .fetch_req0  (fetch_req0),
    .fetch_req1  (fetch_req1),
    .fetch_addr0 (fetch_addr0),
    .fetch_addr1 (fetch_addr1),
    .grant0      (grant0),
    .grant1      (grant1),
    .req_en      (req_en),
    .req_thread  (req_thread),
    .req_addr    (req_addr)
  );

  thread_select i_select (
    .clk (clk),
    .rst (rst),
    .q0  (q0),
    .q1  (q1),
    .iss (iss)
  );

  bundle_issue i_issue (
    .clk           (clk),
    .rst           (rst),
    .credit_return (credit_return),
    .iss           (iss),
    .bundle_valid  (bundle_valid),
    .bundle_thread (bundle_thread),
    .bundle_addr   (bundle_addr),
    .bundle_data   (bundle_data)
  );

endmodule

//--- verification/fetch_front_properties.sv
module fetch_front_properties (
  input logic                     clk,
  input logic                     rst,
  input logic                     req_en,
  input front_types_pkg::thread_t req_thread,
  input logic                     bus_en,
  input front_types_pkg::thread_t bus_thread,
  input logic                     bundle_valid,
  input logic                     credit_return
);

  logic [1:0] outstanding;
  int         credits_left;

  // decoder side view of refills and credits
  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding  <= '0;
      credits_left <= front_cfg_pkg::BUNDLE_CREDITS;
    end else begin
      if (req_en) outstanding[req_thread] <= 1'b1;
      if (bus_en) outstanding[bus_thread] <= 1'b0;
      credits_left <= credits_left - int'(bundle_valid) + int'(credit_return);
    end
  end

  assert property (@(posedge clk) disable iff (rst) bundle_valid |-> credits_left > 0)
    else $error("bundle_valid with no decoder credits left");

  assert property (@(posedge clk) disable iff (rst) req_en |-> !outstanding[req_thread])
    else $error("refill request for a thread with a refill outstanding");

  assert property (@(posedge clk) disable iff (rst) bus_en |-> outstanding[bus_thread])
    else $error("refill without a request");

endmodule

bind fetch_front fetch_front_properties i_props (.*);

//--- verification/fetch_front_tb.sv
module fetch_front_tb;

  localparam int MAX_CYCLES = 1000;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     redirect;
  logic                     bus_en;
  logic                     credit_return;
  logic                     req_en;
  logic                     bundle_valid;
  front_types_pkg::thread_t redirect_thread;
  front_types_pkg::thread_t bus_thread;
  front_types_pkg::thread_t req_thread;
  front_types_pkg::thread_t bundle_thread;
  front_types_pkg::addr_t   redirect_addr;
  front_types_pkg::addr_t   req_addr;
  front_types_pkg::addr_t   bundle_addr;
  front_types_pkg::bundle_t bus_data;
  front_types_pkg::bundle_t bundle_data;

  // timed commands from the stimulus file
  string       cmd_op[$];
  int          cmd_cycle[$];
  int          cmd_thread[$];
  logic [31:0] cmd_value[$];
  int          cmd_count[$];

  logic [31:0]              mem_seed;
  logic [31:0]              rng = 32'hc3d19f7c;
  int                       expect_count[2];
  int                       end_cycle = MAX_CYCLES + 1;
  int                       err[1:6];
  int                       received[2];
  logic                     pend_valid[2];
  int                       pend_delay[2];
  front_types_pkg::addr_t   pend_addr[2];
  front_types_pkg::addr_t   exp_addr[2];
  logic                     redir_check[2];
  int                       outstanding;
  int                       ret_left;
  int                       redir_left;
  int                       redir_seen;
  int                       alt_seen;
  logic                     credit_seen;
  front_types_pkg::thread_t redir_t;
  front_types_pkg::thread_t prev_thread;
  front_types_pkg::addr_t   redir_a;

  fetch_front i_dut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y ^= y << 13;
    y ^= y >> 17;
    y ^= y << 5;
    return y;
  endfunction

  // bus memory contents
  function automatic front_types_pkg::bundle_t mem_value(input front_types_pkg::addr_t a);
    return {xorshift(mem_seed ^ {16'h0, a}), xorshift(mem_seed ^ {a, 16'h0} ^ 32'h1)};
  endfunction

  task automatic read_stimulus();
    int          fd;
    string       line;
    string       op;
    int          c;
    int          t;
    logic [31:0] v;
    int          n;
    fd = $fopen("verification/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file could not be opened");
      err[6]++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%s %d %d %h %d", op, c, t, v, n) == 5 && op[0] != "#") begin
        case (op)
          "seed":   mem_seed = v;
          "expect": expect_count[t] = n;
          "end":    end_cycle = c;
          default: begin
            cmd_op.push_back(op);
            cmd_cycle.push_back(c);
            cmd_thread.push_back(t);
            cmd_value.push_back(v);
            cmd_count.push_back(n);
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  task automatic report_test(input int n, input string name);
    $display("test %0d %s: %s", n, name, (err[n] == 0) ? "pass" : "FAIL");
  endtask

  task automatic check_quiet();
    assert (bundle_valid === 1'b0) else begin
      $display("Error: bundle_valid = %h, expected 0", bundle_valid);
      err[1]++;
    end
    assert (req_en === 1'b0) else begin
      $display("Error: req_en = %h, expected 0", req_en);
      err[1]++;
    end
  endtask

  task automatic drive_cycle(input int k);
    redirect      = 1'b0;
    bus_en        = 1'b0;
    credit_return = 1'b0;
    foreach (cmd_op[i]) begin
      if (cmd_cycle[i] == k && cmd_op[i] == "redir") begin
        redir_left = cmd_count[i];
        redir_t    = cmd_thread[i][0];
        redir_a    = cmd_value[i][15:0];
      end else if (cmd_cycle[i] == k && cmd_op[i] == "credit") begin
        if (!credit_seen) begin
          assert (received[0] + received[1] == front_cfg_pkg::BUNDLE_CREDITS) else begin
            $display("Error: bundle count %h under credit hold, expected %h",
                     received[0] + received[1], front_cfg_pkg::BUNDLE_CREDITS);
            err[3]++;
          end
          report_test(3, "credit hold");
        end
        credit_seen = 1'b1;
        ret_left += cmd_count[i];
      end
    end
    if (redir_left > 0) begin
      redirect        = 1'b1;
      redirect_thread = redir_t;
      redirect_addr   = redir_a;
      redir_left--;
    end
    // decoder gives back only what it has received
    if (ret_left > 0 && outstanding > 0) begin
      credit_return = 1'b1;
      ret_left--;
      outstanding--;
    end
    for (int t = 0; t < 2; t++) begin
      if (pend_valid[t] && pend_delay[t] > 0) pend_delay[t]--;
    end
    for (int t = 0; t < 2; t++) begin
      if (!bus_en && pend_valid[t] && pend_delay[t] == 0) begin
        bus_en        = 1'b1;
        bus_thread    = t[0];
        bus_data      = mem_value(pend_addr[t]);
        pend_valid[t] = 1'b0;
      end
    end
  endtask

  task automatic check_bundle();
    front_types_pkg::thread_t t;
    t = bundle_thread;
    received[t]++;
    outstanding++;
    assert (bundle_addr == exp_addr[t]) else begin
      $display("Error: bundle_addr = %h, expected %h", bundle_addr, exp_addr[t]);
      err[2]++;
    end
    assert (bundle_data == mem_value(exp_addr[t])) else begin
      $display("Error: bundle_data = %h, expected %h", bundle_data, mem_value(exp_addr[t]));
      err[2]++;
    end
    if (redir_check[t]) begin
      redir_seen++;
      redir_check[t] = 1'b0;
      assert (bundle_addr == exp_addr[t]) else begin
        $display("Error: bundle_addr = %h after redirect, expected %h", bundle_addr, exp_addr[t]);
        err[5]++;
      end
    end
    // both queues stay full across each credit burst
    if (credit_seen) begin
      alt_seen++;
      assert (t != prev_thread) else begin
        $display("Error: bundle_thread = %h, expected %h", t, ~prev_thread);
        err[4]++;
      end
    end
    prev_thread = t;
    exp_addr[t] = exp_addr[t] + 1'b1;
  endtask

  task automatic sample_cycle();
    if (bundle_valid) check_bundle();
    if (redirect) begin
      exp_addr[redirect_thread]    = redirect_addr;
      redir_check[redirect_thread] = 1'b1;
    end
    if (req_en) begin
      assert (!pend_valid[req_thread]) else begin
        $display("second refill request for thread %0d while one is outstanding", req_thread);
        err[2]++;
      end
      rng                    = xorshift(rng);
      pend_valid[req_thread] = 1'b1;
      pend_addr[req_thread]  = req_addr;
      pend_delay[req_thread] = 1 + int'(rng[1:0]);
    end
  endtask

  initial begin
    int   cycle;
    int   total;
    int   passed;
    logic timed_out;
    rst             = 1'b1;
    redirect        = 1'b0;
    redirect_thread = 1'b0;
    redirect_addr   = '0;
    bus_en          = 1'b0;
    bus_thread      = 1'b0;
    bus_data        = '0;
    credit_return   = 1'b0;
    pend_valid      = '{1'b0, 1'b0};
    redir_check     = '{1'b0, 1'b0};
    exp_addr        = '{front_cfg_pkg::THREAD0_RESET_ADDR, front_cfg_pkg::THREAD1_RESET_ADDR};
    credit_seen     = 1'b0;
    prev_thread     = 1'b0;
    read_stimulus();
    repeat (7) begin
      @(posedge clk);
      @(negedge clk);
      check_quiet();
    end
    report_test(1, "reset quiet");
    cycle     = 0;
    timed_out = 1'b0;
    while (cycle <= end_cycle && !timed_out) begin
      if (cycle >= MAX_CYCLES) begin
        $display("run did not reach its end command within %0d cycles", MAX_CYCLES);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        rst = 1'b0;
        drive_cycle(cycle);
        @(negedge clk);
        sample_cycle();
        cycle++;
      end
    end
    assert (alt_seen > 0) else begin
      $display("no bundle arrived after the credit hold");
      err[4]++;
    end
    assert (redir_seen > 0) else begin
      $display("no bundle followed a redirect");
      err[5]++;
    end
    for (int t = 0; t < 2; t++) begin
      assert (received[t] == expect_count[t]) else begin
        $display("Error: thread %0d bundle count = %h, expected %h", t, received[t],
                 expect_count[t]);
        err[6]++;
      end
    end
    report_test(2, "stream order");
    report_test(4, "thread alternation");
    report_test(5, "redirect");
    report_test(6, "bundle totals");
    total  = 0;
    passed = 0;
    for (int i = 1; i <= 6; i++) begin
      total += err[i];
      if (err[i] == 0) passed++;
    end
    $display("%0d of 6 tests passed, %0d errors", passed, total);
    if (total == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verification/fetch_stimulus.txt
# op cycle thread value(hex) count
# redir holds redirect for count cycles, credit returns count credits
seed    0   0 5a17e3b1 0
redir   0   1 0100     40
credit  80  0 0        4
credit  130 0 0        4
redir   150 0 0400     1
credit  190 0 0        4
redir   210 1 0800     1
credit  250 0 0        4
end     300 0 0        0
# expected bundles per thread
expect  0   0 0        12
expect  0   1 0        8

//--- files.f
design/front_cfg_pkg.sv
design/front_types_pkg.sv
design/front_ifs.sv
design/thread_fetch.sv
design/bus_request_arb.sv
design/thread_select.sv
design/bundle_issue.sv
design/fetch_front.sv
verification/fetch_front_properties.sv
verification/fetch_front_tb.sv

//--- Bender.yml
package:
  name: fetch_front

sources:
  - design/front_cfg_pkg.sv
  - design/front_types_pkg.sv
  - design/front_ifs.sv
  - design/thread_fetch.sv
  - design/bus_request_arb.sv
  - design/thread_select.sv
  - design/bundle_issue.sv
  - design/fetch_front.sv
  - target: simulation
    files:
      - verification/fetch_front_properties.sv
      - verification/fetch_front_tb.sv
